// ==== nn_params.svh ====
`ifndef NN_PARAMS_SVH
`define NN_PARAMS_SVH

// width of one feature, weight and sum.
`define NN_FEATURE_WIDTH 16

// features per sample, split evenly over the two engines.
`define NN_FEATURE_COUNT 30
`define NN_HALF_COUNT 15

// step counter inside one engine.
`define NN_INDEX_WIDTH 4

`endif

// ==== nnCtrlPkg.sv ====
package nnCtrlPkg;

	// activation picked per sample.
	typedef enum logic
	{
		ACT_NONE = 1'b0,
		ACT_RELU = 1'b1
	} actOp_t;

	typedef enum logic [1:0]
	{
		IN_IDLE,
		IN_START,
		IN_WAIT_RELEASE
	} intakeState_t;

	typedef enum logic [1:0] {MAC_IDLE, MAC_RUN, MAC_HOLD} macState_t;

	typedef enum logic [1:0] {OUT_EMPTY, OUT_REQ, OUT_WAIT_DROP} outState_t;

endpackage

// ==== nnDataPkg.sv ====
`include "nn_params.svh"

package nnDataPkg;

	// two's complement, all arithmetic wraps at this width.
	typedef logic signed [`NN_FEATURE_WIDTH-1:0] feature_t;

	typedef struct packed
	{
		nnCtrlPkg::actOp_t act;
		feature_t [`NN_FEATURE_COUNT-1:0] features;
	} sample_t;

	// half of the dot product, with the select it belongs to.
	typedef struct packed
	{
		nnCtrlPkg::actOp_t act;
		feature_t sum;
	} partial_t;

	localparam feature_t WEIGHTS [0:`NN_FEATURE_COUNT-1] = '{
		-16'sd364, 16'sd34, 16'sd770, -16'sd765, -16'sd139,
		16'sd496, 16'sd46, -16'sd344, 16'sd112, -16'sd226,
		-16'sd221, -16'sd74, 16'sd269, -16'sd260, 16'sd256,
		-16'sd338, 16'sd23, 16'sd389, -16'sd135, -16'sd25,
		16'sd143, 16'sd631, -16'sd38, 16'sd285, -16'sd400,
		-16'sd246, -16'sd71, -16'sd32, 16'sd613, 16'sd155
	};

	localparam feature_t BIAS = -16'sd86;

endpackage

// ==== sampleIntake.sv ====
`timescale 1ns/10ps

module sampleIntake
(
	input  logic clk,
	input  logic reset,
	input  logic sampleReq,
	input  nnDataPkg::sample_t sample,
	input  logic enginesBusy,
	output logic sampleAck,
	output logic start,
	output nnDataPkg::sample_t captured
);

	nnCtrlPkg::intakeState_t state;
	nnCtrlPkg::intakeState_t nextState;
	logic accept;

	// a request is only taken while neither engine holds work.
	assign accept = (state == nnCtrlPkg::IN_IDLE) && sampleReq && !enginesBusy;

	always_comb
	begin
		nextState = state;
		case (state)
			nnCtrlPkg::IN_IDLE:
				if (accept)
					nextState = nnCtrlPkg::IN_START;
			nnCtrlPkg::IN_START:
				if (sampleReq)
					nextState = nnCtrlPkg::IN_WAIT_RELEASE;
				else
					nextState = nnCtrlPkg::IN_IDLE;
			nnCtrlPkg::IN_WAIT_RELEASE:
				if (!sampleReq)
					nextState = nnCtrlPkg::IN_IDLE;
			default:
				nextState = nnCtrlPkg::IN_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= nnCtrlPkg::IN_IDLE;
		else
			state <= nextState;
	end

	// sample held here until the next accepted request.
	always_ff @(posedge clk)
	begin
		if (accept)
			captured <= sample;
	end

	// ack stays up from capture until the source lets go.
	assign sampleAck = (state != nnCtrlPkg::IN_IDLE);

	// engines read captured in this same cycle.
	assign start = (state == nnCtrlPkg::IN_START);

endmodule

// ==== partialDotProduct.sv ====
`timescale 1ns/10ps
`include "nn_params.svh"

module partialDotProduct
#(
	parameter int firstIndex = 0
)
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  nnDataPkg::sample_t captured,
	input  logic partialTake,
	output logic busy,
	output logic partialValid,
	output nnDataPkg::partial_t partial
);

	localparam int selWidth = $clog2(`NN_FEATURE_COUNT);
	localparam logic [`NN_INDEX_WIDTH-1:0] lastIndex = `NN_INDEX_WIDTH'(`NN_HALF_COUNT - 1);

	nnCtrlPkg::macState_t state;
	logic [`NN_INDEX_WIDTH-1:0] index;
	logic [selWidth-1:0] featureIndex;
	nnDataPkg::feature_t product;
	nnDataPkg::feature_t acc;
	nnCtrlPkg::actOp_t actHold;

	assign featureIndex = selWidth'(firstIndex) + selWidth'(index);

	// only the low 16 bits of each product are kept.
	assign product = nnDataPkg::feature_t'(captured.features[featureIndex] *
		nnDataPkg::WEIGHTS[featureIndex]);

	// index sits at zero while idle so the start cycle does the first MAC.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnCtrlPkg::MAC_IDLE;
			index <= '0;
		end
		else
		begin
			case (state)
				nnCtrlPkg::MAC_IDLE:
					if (start)
					begin
						state <= nnCtrlPkg::MAC_RUN;
						index <= `NN_INDEX_WIDTH'(1);
					end
				nnCtrlPkg::MAC_RUN:
					if (index == lastIndex)
						state <= nnCtrlPkg::MAC_HOLD;
					else
						index <= index + `NN_INDEX_WIDTH'(1);
				nnCtrlPkg::MAC_HOLD:
					if (partialTake)
					begin
						state <= nnCtrlPkg::MAC_IDLE;
						index <= '0;
					end
				default:
					state <= nnCtrlPkg::MAC_IDLE;
			endcase
		end
	end

	// accumulator wraps at 16 bits.
	always_ff @(posedge clk)
	begin
		if (state == nnCtrlPkg::MAC_IDLE && start)
		begin
			acc <= product;
			actHold <= captured.act;
		end
		else if (state == nnCtrlPkg::MAC_RUN)
			acc <= acc + product;
	end

	assign busy = (state != nnCtrlPkg::MAC_IDLE);
	assign partialValid = (state == nnCtrlPkg::MAC_HOLD);
	assign partial.sum = acc;
	assign partial.act = actHold;

endmodule

// ==== neuronCombiner.sv ====
`timescale 1ns/10ps
`include "nn_params.svh"

module neuronCombiner
(
	input  logic clk,
	input  logic reset,
	input  logic lowValid,
	input  nnDataPkg::partial_t lowPartial,
	input  logic highValid,
	input  nnDataPkg::partial_t highPartial,
	input  logic resultAck,
	output logic partialTake,
	output logic resultReq,
	output nnDataPkg::feature_t result
);

	nnCtrlPkg::outState_t state;
	nnDataPkg::feature_t total;
	nnDataPkg::feature_t activated;
	logic reluOn;

	// both halves carry the same select, either one is enough.
	assign reluOn = (lowPartial.act == nnCtrlPkg::ACT_RELU) ||
		(highPartial.act == nnCtrlPkg::ACT_RELU);

	// sum wraps modulo 2^16 like the products.
	assign total = lowPartial.sum + highPartial.sum + nnDataPkg::BIAS;

	// relu clamps on the sign bit only.
	assign activated = (reluOn && total[`NN_FEATURE_WIDTH-1]) ? '0 : total;

	// one pulse releases both engines together.
	assign partialTake = (state == nnCtrlPkg::OUT_EMPTY) && lowValid && highValid;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= nnCtrlPkg::OUT_EMPTY;
		else
		begin
			case (state)
				nnCtrlPkg::OUT_EMPTY:
					if (partialTake)
						state <= nnCtrlPkg::OUT_REQ;
				nnCtrlPkg::OUT_REQ:
					if (resultAck)
						state <= nnCtrlPkg::OUT_WAIT_DROP;
				nnCtrlPkg::OUT_WAIT_DROP:
					if (!resultAck)
						state <= nnCtrlPkg::OUT_EMPTY;
				default:
					state <= nnCtrlPkg::OUT_EMPTY;
			endcase
		end
	end

	// result stays put until the next take.
	always_ff @(posedge clk)
	begin
		if (partialTake)
			result <= activated;
	end

	assign resultReq = (state == nnCtrlPkg::OUT_REQ);

endmodule

// ==== neuronNode.sv ====
`timescale 1ns/10ps
`include "nn_params.svh"

module neuronNode
(
	input  logic clk,
	input  logic reset,
	input  logic sampleReq,
	input  nnDataPkg::sample_t sample,
	output logic sampleAck,
	output logic resultReq,
	output nnDataPkg::feature_t result,
	input  logic resultAck
);

	nnDataPkg::sample_t captured;
	nnDataPkg::partial_t lowPartial;
	nnDataPkg::partial_t highPartial;
	logic start;
	logic lowBusy;
	logic highBusy;
	logic enginesBusy;
	logic lowValid;
	logic highValid;
	logic partialTake;

	// intake waits while either half still holds a partial.
	assign enginesBusy = lowBusy | highBusy;

	sampleIntake intake
	(
		.clk(clk),
		.reset(reset),
		.sampleReq(sampleReq),
		.sample(sample),
		.enginesBusy(enginesBusy),
		.sampleAck(sampleAck),
		.start(start),
		.captured(captured)
	);

	partialDotProduct #(.firstIndex(0)) lowHalf
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.captured(captured),
		.partialTake(partialTake),
		.busy(lowBusy),
		.partialValid(lowValid),
		.partial(lowPartial)
	);

	partialDotProduct #(.firstIndex(`NN_HALF_COUNT)) highHalf
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.captured(captured),
		.partialTake(partialTake),
		.busy(highBusy),
		.partialValid(highValid),
		.partial(highPartial)
	);

	neuronCombiner combiner
	(
		.clk(clk),
		.reset(reset),
		.lowValid(lowValid),
		.lowPartial(lowPartial),
		.highValid(highValid),
		.highPartial(highPartial),
		.resultAck(resultAck),
		.partialTake(partialTake),
		.resultReq(resultReq),
		.result(result)
	);

endmodule

// ==== neuronNode_props.sv ====
`timescale 1ns/10ps

module neuronNode_props
(
	input logic clk,
	input logic reset,
	input logic sampleReq,
	input logic sampleAck,
	input logic resultReq,
	input logic resultAck,
	input nnDataPkg::feature_t result
);

	// the intake answers a request it saw on the previous edge.
	ackFollowsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(sampleAck) |-> $past(sampleReq))
		else $error("sampleAck rose with no sampleReq pending");

	reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset)
		resultReq && !resultAck |=> resultReq)
		else $error("resultReq dropped before resultAck");

	resultStable: assert property (@(posedge clk) disable iff (reset)
		resultReq |=> !resultReq || $stable(result))
		else $error("result changed while resultReq was high");

	// no disable here, this one is about reset itself.
	quietAfterReset: assert property (@(posedge clk)
		reset |=> !sampleAck && !resultReq)
		else $error("sampleAck or resultReq high after reset");

endmodule

bind neuronNode neuronNode_props props
(
	.clk(clk),
	.reset(reset),
	.sampleReq(sampleReq),
	.sampleAck(sampleAck),
	.resultReq(resultReq),
	.resultAck(resultAck),
	.result(result)
);

// ==== neuronNodeChecker.sv ====
`timescale 1ns/10ps
`include "nn_params.svh"

module neuronNodeChecker
(
	input  logic clk,
	input  logic reset,
	input  nnDataPkg::sample_t sample,
	input  logic sampleAck,
	input  logic resultReq,
	input  nnDataPkg::feature_t result,
	output int acceptedCount,
	output int resultCount,
	output int errorCount
);

	nnDataPkg::feature_t expectQ [$];
	nnCtrlPkg::actOp_t actQ [$];
	nnDataPkg::feature_t expected;
	nnCtrlPkg::actOp_t act;
	bit ackPrev;
	bit reqPrev;
	bit resetPrev;
	int newErrors;

	// bias first, then each product cut to its low 16 bits.
	function automatic nnDataPkg::feature_t modelResult(input nnDataPkg::sample_t s);
		logic [31:0] wide;
		logic [15:0] sum;
		int i;
		begin
			sum = nnDataPkg::BIAS;
			for (i = 0; i < `NN_FEATURE_COUNT; i++)
			begin
				wide = {16'h0, s.features[i]} * {16'h0, nnDataPkg::WEIGHTS[i]};
				sum = sum + wide[15:0];
			end
			if (s.act == nnCtrlPkg::ACT_RELU && sum[15])
				sum = 16'h0;
			modelResult = sum;
		end
	endfunction

	always @(posedge clk)
	begin
		newErrors = 0;
		if (resetPrev && !reset)
		begin
			if (sampleAck || resultReq)
			begin
				$display("sampleAck or resultReq was still high when reset ended");
				newErrors++;
			end
			else
				$display("[PASS] reset: sampleAck and resultReq low");
		end
		if (reset)
		begin
			expectQ.delete();
			actQ.delete();
		end
		else
		begin
			// expected value is fixed when the sample is accepted.
			if (sampleAck && !ackPrev)
			begin
				expectQ.push_back(modelResult(sample));
				actQ.push_back(sample.act);
				acceptedCount <= acceptedCount + 1;
			end
			if (resultReq && !reqPrev)
			begin
				if (expectQ.size() == 0)
				begin
					$display("result %0d arrived with no accepted sample waiting", result);
					newErrors++;
				end
				else
				begin
					expected = expectQ.pop_front();
					act = actQ.pop_front();
					if (result !== expected)
					begin
						$display("[FAIL] sample %0d (%s): expected %0d, actual %0d",
							resultCount, (act == nnCtrlPkg::ACT_RELU) ? "relu" : "none",
							expected, result);
						newErrors++;
					end
					else
						$display("[PASS] sample %0d (%s): result %0d", resultCount,
							(act == nnCtrlPkg::ACT_RELU) ? "relu" : "none", result);
				end
				resultCount <= resultCount + 1;
			end
		end
		ackPrev <= sampleAck;
		reqPrev <= resultReq;
		resetPrev <= reset;
		errorCount <= errorCount + newErrors;
	end

endmodule

// ==== neuronNode_tb.sv ====
`timescale 1ns/10ps
`include "nn_params.svh"

module neuronNode_tb;

	localparam int clockPeriod = 40;
	localparam int randomCount = 40;
	localparam int slowCount = 12;
	localparam int sampleTotal = 2 + randomCount + slowCount + 1;
	localparam int timeLimit = (sampleTotal * 60 + 200) * clockPeriod;

	logic clk;
	logic reset;
	logic sampleReq;
	nnDataPkg::sample_t sample;
	logic sampleAck;
	logic resultReq;
	nnDataPkg::feature_t result;
	logic resultAck;

	int seed;
	int sentCount;
	int acceptedCount;
	int resultCount;
	int errorCount;
	int ackDelay [0:sampleTotal-1];
	int sinkIndex;
	int ackWait;
	int gap;
	int i;
	nnDataPkg::sample_t stimulus;

	neuronNode DUT
	(
		.clk(clk),
		.reset(reset),
		.sampleReq(sampleReq),
		.sample(sample),
		.sampleAck(sampleAck),
		.resultReq(resultReq),
		.result(result),
		.resultAck(resultAck)
	);

	neuronNodeChecker resultCheck
	(
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleAck(sampleAck),
		.resultReq(resultReq),
		.result(result),
		.acceptedCount(acceptedCount),
		.resultCount(resultCount),
		.errorCount(errorCount)
	);

	always #(clockPeriod / 2) clk = ~clk;

	task automatic randomRange(input int low, input int high, output int value);
		logic [31:0] r;
		begin
			r = $random(seed);
			value = low + int'(r[15:0]) % (high - low + 1);
		end
	endtask

	// full 16-bit features, so products and sums wrap often.
	task automatic makeRandomSample(output nnDataPkg::sample_t value);
		logic [31:0] r;
		int k;
		begin
			for (k = 0; k < `NN_FEATURE_COUNT; k++)
			begin
				r = $random(seed);
				value.features[k] = r[15:0];
			end
			r = $random(seed);
			value.act = r[0] ? nnCtrlPkg::ACT_RELU : nnCtrlPkg::ACT_NONE;
		end
	endtask

	// one full four-phase cycle on the input side.
	task automatic sendSample(input nnDataPkg::sample_t value);
		begin
			sample <= value;
			sampleReq <= 1'b1;
			@(posedge clk);
			while (!sampleAck)
				@(posedge clk);
			sampleReq <= 1'b0;
			@(posedge clk);
			while (sampleAck)
				@(posedge clk);
			sentCount++;
		end
	endtask

	task automatic waitDrained();
		begin
			while (resultCount < sentCount || resultReq || resultAck)
				@(posedge clk);
			@(posedge clk);
		end
	endtask

	task automatic finishRun();
		begin
			if (resultCount != acceptedCount || acceptedCount != sentCount)
				$display("result count %0d does not match %0d accepted of %0d sent samples",
					resultCount, acceptedCount, sentCount);
			$display("results %0d, accepted %0d, sent %0d, errors %0d",
				resultCount, acceptedCount, sentCount, errorCount);
			if (errorCount == 0 && resultCount == acceptedCount && acceptedCount == sentCount)
				$display("** PASS **");
			else
				$display("** FAIL **");
			$finish;
		end
	endtask

	// sink side, resultAck after a per-result delay.
	always @(posedge clk)
	begin
		if (reset)
		begin
			resultAck <= 1'b0;
			ackWait <= 0;
		end
		else if (resultReq && !resultAck)
		begin
			if (ackWait >= ((sinkIndex < sampleTotal) ? ackDelay[sinkIndex] : 0))
			begin
				resultAck <= 1'b1;
				ackWait <= 0;
			end
			else
				ackWait <= ackWait + 1;
		end
		else if (resultAck && !resultReq)
		begin
			resultAck <= 1'b0;
			sinkIndex <= sinkIndex + 1;
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		sampleReq = 1'b0;
		sample = '0;
		resultAck = 1'b0;
		seed = 32'h6b34;
		// the slow block holds results long enough to stall the engines.
		for (i = 0; i < sampleTotal; i++)
		begin
			if (i >= 2 + randomCount && i < 2 + randomCount + slowCount)
				randomRange(20, 35, ackDelay[i]);
			else
				randomRange(0, 8, ackDelay[i]);
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		stimulus = '0;
		stimulus.act = nnCtrlPkg::ACT_RELU;
		sendSample(stimulus);
		stimulus.act = nnCtrlPkg::ACT_NONE;
		sendSample(stimulus);
		for (i = 0; i < randomCount; i++)
		begin
			randomRange(0, 5, gap);
			repeat (gap) @(posedge clk);
			makeRandomSample(stimulus);
			sendSample(stimulus);
		end
		for (i = 0; i < slowCount; i++)
		begin
			makeRandomSample(stimulus);
			sendSample(stimulus);
		end
		waitDrained();
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		makeRandomSample(stimulus);
		sendSample(stimulus);
		waitDrained();
		finishRun();
	end

	initial
	begin
		#(timeLimit);
		$display("timeout: the run did not finish within %0d ns", timeLimit);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
nnCtrlPkg.sv
nnDataPkg.sv
sampleIntake.sv
partialDotProduct.sv
neuronCombiner.sv
neuronNode.sv
neuronNode_props.sv
neuronNodeChecker.sv
neuronNode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= neuronNode_tb
LOG ?= sim.log
SEED_ARGS ?=
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SEED_ARGS) 2>&1 | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
